//--- mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// request queue entries
`define REQ_DEPTH 2

// lines held by the line memory
`define MEM_LINES 16

// address bits below the line index, 16 bytes per line
`define LINE_OFFSET 4

// cycles from pop to resp
`define MEM_LATENCY 4

`endif

//--- lc3b_types.sv
`default_nettype none

`include "mem_cfg.svh"

package lc3b_types;

	// address or data word
	typedef logic [15:0] lc3b_word;

	// one cache line, eight words
	typedef logic [127:0] lc3b_c_block;

	// selects a line in the line memory
	typedef logic [$clog2(`MEM_LINES)-1:0] lc3b_line_idx;

endpackage : lc3b_types

`default_nettype wire

//--- pmem_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package pmem_pkg;

	// which cache a request belongs to
	typedef enum logic {
		OWNER_I = 1'b0,
		OWNER_D = 1'b1
	} pmem_owner_t;

	// one queued line request
	typedef struct packed {
		pmem_owner_t owner;
		logic write;
		lc3b_types::lc3b_word address;
		lc3b_types::lc3b_c_block wdata;
	} pmem_req_t;

	// line index sits just above the byte offset
	function automatic lc3b_types::lc3b_line_idx line_of(input lc3b_types::lc3b_word address);
		return address[`LINE_OFFSET +: $bits(lc3b_types::lc3b_line_idx)];
	endfunction

endpackage : pmem_pkg

`default_nettype wire

//--- line_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface line_req_if;

	// head of the request queue
	logic req_valid;
	pmem_pkg::pmem_req_t req;
	logic req_take;

	// response from the line memory
	logic resp;
	pmem_pkg::pmem_owner_t resp_owner;
	lc3b_types::lc3b_c_block resp_rdata;

	modport queue (
		output req_valid,
		output req,
		input req_take
	);

	modport memory (
		input req_valid,
		input req,
		output req_take,
		output resp,
		output resp_owner,
		output resp_rdata
	);

	// arbiter only steers responses
	modport arbiter (
		input resp,
		input resp_owner,
		input resp_rdata
	);

endinterface : line_req_if

`default_nettype wire

//--- pmem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module pmem_arbiter
(
	input logic clk,
	input logic rst_n,

	// instruction cache
	input logic i_read,
	input lc3b_types::lc3b_word i_address,

	// data cache
	input logic d_read,
	input logic d_write,
	input lc3b_types::lc3b_word d_address,
	input lc3b_types::lc3b_c_block d_wdata,

	output logic i_resp,
	output logic d_resp,
	output lc3b_types::lc3b_c_block rdata,

	// request queue push side
	output logic push,
	output pmem_pkg::pmem_req_t push_req,
	input logic full,

	line_req_if.arbiter mem
);

	logic i_issued;
	logic d_issued;
	logic i_pend;
	logic d_pend;
	logic pick_d;

	// a request waiting to enter the queue
	assign i_pend = i_read && !i_issued;
	assign d_pend = (d_read || d_write) && !d_issued;

	// data cache first
	assign pick_d = d_pend;

	assign push = !full && (d_pend || i_pend);

	always_comb begin
		if (pick_d) begin
			push_req.owner = pmem_pkg::OWNER_D;
			push_req.write = d_write;
			push_req.address = d_address;
			push_req.wdata = d_wdata;
		end else begin
			push_req.owner = pmem_pkg::OWNER_I;
			push_req.write = 1'b0;
			push_req.address = i_address;
			push_req.wdata = '0;
		end
	end

	// issued marks live until the owner sees its resp
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			i_issued <= 1'b0;
			d_issued <= 1'b0;
		end else begin
			if (i_resp)
				i_issued <= 1'b0;
			else if (push && !pick_d)
				i_issued <= 1'b1;

			if (d_resp)
				d_issued <= 1'b0;
			else if (push && pick_d)
				d_issued <= 1'b1;
		end
	end

	// route the response by owner tag
	assign i_resp = mem.resp && (mem.resp_owner == pmem_pkg::OWNER_I);
	assign d_resp = mem.resp && (mem.resp_owner == pmem_pkg::OWNER_D);
	assign rdata = mem.resp_rdata;

	// a resp must answer a request this arbiter issued earlier
	i_resp_has_owner: assert property (
		@(posedge clk) disable iff (!rst_n) i_resp |-> i_issued
	) else $error("i_resp with no instruction request outstanding");

	d_resp_has_owner: assert property (
		@(posedge clk) disable iff (!rst_n) d_resp |-> d_issued
	) else $error("d_resp with no data request outstanding");

endmodule : pmem_arbiter

`default_nettype wire

//--- req_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_cfg.svh"

module req_queue
(
	input logic clk,
	input logic rst_n,

	input logic push,
	input pmem_pkg::pmem_req_t push_req,
	output logic full,

	line_req_if.queue q
);

	localparam int PTR_W = (`REQ_DEPTH > 1) ? $clog2(`REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

	pmem_pkg::pmem_req_t entries [`REQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`REQ_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(`REQ_DEPTH));
	assign q.req_valid = (count != '0);
	assign q.req = entries[rd_ptr];

	assign do_push = push && !full;
	assign do_pop = q.req_take && q.req_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// push and pop together leave the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= push_req;
	end

	no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!rst_n) q.req_take |-> q.req_valid
	) else $error("pop from empty queue");

	no_push_when_full: assert property (
		@(posedge clk) disable iff (!rst_n) push |-> !full
	) else $error("push into full queue");

endmodule : req_queue

`default_nettype wire

//--- line_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_cfg.svh"

module line_memory
(
	input logic clk,
	input logic rst_n,

	line_req_if.memory mem
);

	localparam int LAT_W = (`MEM_LATENCY > 1) ? $clog2(`MEM_LATENCY) : 1;

	lc3b_types::lc3b_c_block lines [`MEM_LINES];
	logic [`MEM_LINES-1:0] written;

	logic busy;
	logic [LAT_W-1:0] cnt;
	pmem_pkg::pmem_req_t cur;
	lc3b_types::lc3b_line_idx cur_idx;
	logic done;

	assign cur_idx = pmem_pkg::line_of(cur.address);

	// pop whenever idle
	assign mem.req_take = !busy && mem.req_valid;

	// last cycle of the access
	assign done = busy && (cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (mem.req_take) begin
			busy <= 1'b1;
			cnt <= LAT_W'(`MEM_LATENCY - 1);
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

	// latched request, payload only
	always_ff @(posedge clk) begin
		if (mem.req_take)
			cur <= mem.req;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			written <= '0;
		else if (done && cur.write)
			written[cur_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (done && cur.write)
			lines[cur_idx] <= cur.wdata;
	end

	assign mem.resp = done;
	assign mem.resp_owner = cur.owner;
	// untouched lines read as zero
	assign mem.resp_rdata = written[cur_idx] ? lines[cur_idx] : '0;

	resp_one_cycle: assert property (
		@(posedge clk) disable iff (!rst_n) mem.resp |=> !mem.resp
	) else $error("resp held for two cycles");

endmodule : line_memory

`default_nettype wire

//--- mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem
(
	input logic clk,
	input logic rst_n,

	// instruction cache side
	input logic i_read,
	input lc3b_types::lc3b_word i_address,
	output logic i_resp,

	// data cache side
	input logic d_read,
	input logic d_write,
	input lc3b_types::lc3b_word d_address,
	input lc3b_types::lc3b_c_block d_wdata,
	output logic d_resp,

	// shared read data, valid with resp
	output lc3b_types::lc3b_c_block rdata
);

	logic push;
	pmem_pkg::pmem_req_t push_req;
	logic full;

	line_req_if req_bus ();

	pmem_arbiter arbiter
	(
		.clk,
		.rst_n,
		.i_read,
		.i_address,
		.d_read,
		.d_write,
		.d_address,
		.d_wdata,
		.i_resp,
		.d_resp,
		.rdata,
		.push,
		.push_req,
		.full,
		.mem(req_bus.arbiter)
	);

	req_queue queue
	(
		.clk,
		.rst_n,
		.push,
		.push_req,
		.full,
		.q(req_bus.queue)
	);

	line_memory memory
	(
		.clk,
		.rst_n,
		.mem(req_bus.memory)
	);

endmodule : mem_subsystem

`default_nettype wire

//--- tb_mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_cfg.svh"

module tb_mem_subsystem;

	localparam int unsigned SEED = 32'h6449b5d9;
	localparam int RANDOM_OPS = 300;
	localparam int CYCLE_LIMIT = 400 * (2 * `MEM_LATENCY + 8);

	logic clk;
	logic rst_n;
	logic i_read;
	lc3b_types::lc3b_word i_address;
	logic i_resp;
	logic d_read;
	logic d_write;
	lc3b_types::lc3b_word d_address;
	lc3b_types::lc3b_c_block d_wdata;
	logic d_resp;
	lc3b_types::lc3b_c_block rdata;

	// reference copy of the line memory
	lc3b_types::lc3b_c_block model [16];

	// outstanding request of each cache
	logic i_active;
	lc3b_types::lc3b_word i_addr;
	logic d_active;
	logic d_is_write;
	lc3b_types::lc3b_word d_addr;
	lc3b_types::lc3b_c_block d_data;
	logic i_just_done;
	logic d_just_done;
	int i_resp_seen;
	int d_resp_seen;

	string test_name;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int cycle_count = 0;

	mem_subsystem mem_subsystem_i (
		.clk,
		.rst_n,
		.i_read,
		.i_address,
		.i_resp,
		.d_read,
		.d_write,
		.d_address,
		.d_wdata,
		.d_resp,
		.rdata
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: requests still unanswered after %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// 16-byte lines, index in address bits 7:4
	function automatic logic [3:0] line_index(input lc3b_types::lc3b_word addr);
		return addr[7:4];
	endfunction

	function automatic lc3b_types::lc3b_word random_addr(input logic [3:0] line);
		lc3b_types::lc3b_word addr;
		addr = 16'($urandom);
		addr[7:4] = line;
		return addr;
	endfunction

	function automatic lc3b_types::lc3b_c_block random_block();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic check_block(input lc3b_types::lc3b_c_block expected,
			input lc3b_types::lc3b_c_block actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
			errors++;
		end
	endtask

	// one clock edge, then retire any response seen before it
	task automatic tick();
		@(posedge clk);
		i_just_done = 1'b0;
		d_just_done = 1'b0;
		if (i_resp) begin
			i_resp_seen++;
			if (!i_active) begin
				$display("Error in %s: i_resp with no instruction read outstanding", test_name);
				errors++;
			end else begin
				check_block(model[line_index(i_addr)], rdata);
				i_active = 1'b0;
				i_just_done = 1'b1;
				i_read <= 1'b0;
			end
		end
		if (d_resp) begin
			d_resp_seen++;
			if (!d_active) begin
				$display("Error in %s: d_resp with no data request outstanding", test_name);
				errors++;
			end else begin
				if (d_is_write)
					model[line_index(d_addr)] = d_data;
				else
					check_block(model[line_index(d_addr)], rdata);
				d_active = 1'b0;
				d_just_done = 1'b1;
				d_read <= 1'b0;
				d_write <= 1'b0;
			end
		end
	endtask

	task automatic start_i_read(input lc3b_types::lc3b_word addr);
		i_addr = addr;
		i_active = 1'b1;
		i_read <= 1'b1;
		i_address <= addr;
	endtask

	task automatic start_d(input logic write, input lc3b_types::lc3b_word addr,
			input lc3b_types::lc3b_c_block data);
		d_addr = addr;
		d_data = data;
		d_is_write = write;
		d_active = 1'b1;
		d_read <= !write;
		d_write <= write;
		d_address <= addr;
		d_wdata <= data;
	endtask

	task automatic wait_idle();
		while (i_active || d_active)
			tick();
	endtask

	// the leading tick keeps the request low for a cycle after the last resp
	task automatic d_access(input logic write, input lc3b_types::lc3b_word addr,
			input lc3b_types::lc3b_c_block data);
		tick();
		start_d(write, addr, data);
		wait_idle();
	endtask

	task automatic i_access(input lc3b_types::lc3b_word addr);
		tick();
		start_i_read(addr);
		wait_idle();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: FAILED with %0d errors", test_name, errors - test_errors);
			tests_failed++;
		end
	endtask

	task automatic reset_test();
		int c;
		begin_test("reset");
		for (c = 0; c < 14; c++) begin
			@(posedge clk);
			if (i_resp || d_resp) begin
				$display("Error in reset: a response came with no request at cycle %0d", c);
				errors++;
			end
			if (c == 3)
				rst_n <= 1'b1;
		end
		end_test();
	endtask

	task automatic write_then_read_test();
		lc3b_types::lc3b_word addr;
		logic [3:0] line;
		int k;
		begin_test("write_then_read");
		// nothing written yet, so the model expects zero
		d_access(1'b0, random_addr(4'd3), '0);
		d_access(1'b0, random_addr(4'd12), '0);
		for (k = 0; k < 6; k++) begin
			line = 4'($urandom);
			addr = random_addr(line);
			d_access(1'b1, addr, random_block());
			d_access(1'b0, addr, '0);
		end
		end_test();
	endtask

	task automatic cross_cache_test();
		logic [3:0] line;
		int k;
		begin_test("cross_cache");
		for (k = 0; k < 6; k++) begin
			line = 4'($urandom);
			d_access(1'b1, random_addr(line), random_block());
			i_access(random_addr(line));
		end
		end_test();
	endtask

	task automatic simultaneous_test();
		logic [3:0] line;
		int k;
		int i_before;
		int d_before;
		begin_test("simultaneous");
		for (k = 0; k < 8; k++) begin
			tick();
			i_before = i_resp_seen;
			d_before = d_resp_seen;
			line = 4'($urandom);
			start_i_read(random_addr(line));
			// writes go to a neighbouring line so the read result is fixed
			if (k % 2 == 0)
				start_d(1'b0, random_addr(line), '0);
			else
				start_d(1'b1, random_addr(line + 4'd1), random_block());
			wait_idle();
			// stray pulses would show up here
			repeat (2 * `MEM_LATENCY + 2)
				tick();
			if (i_resp_seen != i_before + 1) begin
				$display("Mismatch in %s: expected %0d i_resp pulses, actual %0d",
					test_name, 1, i_resp_seen - i_before);
				errors++;
			end
			if (d_resp_seen != d_before + 1) begin
				$display("Mismatch in %s: expected %0d d_resp pulses, actual %0d",
					test_name, 1, d_resp_seen - d_before);
				errors++;
			end
		end
		end_test();
	endtask

	task automatic random_test();
		int started;
		int i_gap;
		int d_gap;
		logic [3:0] line;
		logic do_write;
		begin_test("random_traffic");
		started = 0;
		i_gap = 0;
		d_gap = 0;
		while (started < RANDOM_OPS || i_active || d_active) begin
			tick();
			if (i_just_done) begin
				i_gap = $urandom_range(3, 0);
			end else if (!i_active && started < RANDOM_OPS) begin
				line = 4'($urandom);
				if (i_gap > 0) begin
					i_gap--;
				end else if (!(d_active && d_is_write && line_index(d_addr) == line)) begin
					start_i_read(random_addr(line));
					started++;
				end
			end
			if (d_just_done) begin
				d_gap = $urandom_range(3, 0);
			end else if (!d_active && started < RANDOM_OPS) begin
				if (d_gap > 0) begin
					d_gap--;
				end else begin
					line = 4'($urandom);
					do_write = 1'($urandom);
					// no write to a line the instruction cache is reading
					if (do_write && i_active && line_index(i_addr) == line)
						do_write = 1'b0;
					start_d(do_write, random_addr(line), random_block());
					started++;
				end
			end
		end
		end_test();
	endtask

	initial begin
		int n;
		void'($urandom(SEED));
		rst_n <= 1'b0;
		i_read <= 1'b0;
		i_address <= '0;
		d_read <= 1'b0;
		d_write <= 1'b0;
		d_address <= '0;
		d_wdata <= '0;
		for (n = 0; n < 16; n++)
			model[n] = '0;
		i_active = 1'b0;
		d_active = 1'b0;
		d_is_write = 1'b0;
		i_addr = '0;
		d_addr = '0;
		d_data = '0;
		i_just_done = 1'b0;
		d_just_done = 1'b0;
		i_resp_seen = 0;
		d_resp_seen = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = "init";

		reset_test();
		write_then_read_test();
		cross_cache_test();
		simultaneous_test();
		random_test();

		$display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule : tb_mem_subsystem

`default_nettype wire

//--- src.f
+incdir+.
lc3b_types.sv
pmem_pkg.sv
line_req_if.sv
pmem_arbiter.sv
req_queue.sv
line_memory.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f src.f --top-module tb_mem_subsystem -o sim_mem_subsystem > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_mem_subsystem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1
